/* gameControl_settings.svh */
// Game controller constants
// Bus widths, tick periods of every timed screen and the score thresholds
`ifndef GAMECONTROL_SETTINGS_SVH
`define GAMECONTROL_SETTINGS_SVH

// ============================================================================
// Widths
// ============================================================================
`define GC_SPEED_W 28
`define GC_SCORE_W 8

// ============================================================================
// Timer periods in clock cycles
// ============================================================================
// Countdown and banner screens
`define GC_GO_TICKS 10
`define GC_BANNER_TICKS 6
// Step period per speed level
`define GC_LEVEL1_TICKS 12
`define GC_LEVEL2_TICKS 8
`define GC_LEVEL3_TICKS 4
// Lose screen hold time
`define GC_LOSE_TICKS 20

// ============================================================================
// Score thresholds
// ============================================================================
`define GC_LEVEL2_SCORE 32
`define GC_LEVEL3_SCORE 64
`define GC_WIN_SCORE 128

`endif

/* gameControl_pkg.sv */
// Game controller types
// Count and score vectors, screen codes, step kinds, levels and FSM states
package gameControl_pkg;

	`include "gameControl_settings.svh"

	// Timer tick count
	typedef logic [`GC_SPEED_W-1:0] speedCount_t;

	// Point total
	typedef logic [`GC_SCORE_W-1:0] score_t;

	// Speed level, ordered so a rise compares as greater
	typedef enum logic [1:0] {
		levelOne,
		levelTwo,
		levelThree
	} level_t;

	// Screen codes seen by the display engine
	typedef enum logic [3:0] {
		screenIdle        = 4'd0,
		screenGo          = 4'd1,
		screenLevel1      = 4'd2,
		screenLevel2      = 4'd3,
		screenLevel3      = 4'd4,
		screenLosePlayer2 = 4'd5,
		screenLosePlayer1 = 4'd6,
		screenWin         = 4'd7,
		screenRun         = 4'd8
	} screen_t;

	// Road step command
	typedef enum logic {
		addCars,
		moveCars
	} stepKind_t;

	// Sequencer FSM
	typedef enum logic [3:0] {
		stateIdle,
		stateGo,
		stateBanner,
		stateRun,
		stateStepOffer,
		stateLose,
		stateWin
	} seqState_t;

endpackage

/* gameControl_if.sv */
// Internal buses of the game controller
// speedTimerIf between sequencer and speed timer
// scoreIf between sequencer and score keeper
`timescale 1ns/1ns

// ============================================================================
// Speed timer bus
// ============================================================================
interface speedTimerIf
	import gameControl_pkg::*;
();
	// Load pulse captures period and clears the count
	logic        load;
	speedCount_t period;
	// Count enable
	logic        run;
	// One-cycle pulse at the end of a period
	logic        expired;

	modport sequencer (
		output load,
		output period,
		output run,
		input  expired
	);

	modport timer (
		input  load,
		input  period,
		input  run,
		output expired
	);
endinterface

// ============================================================================
// Score bus
// ============================================================================
interface scoreIf
	import gameControl_pkg::*;
();
	logic   clear;
	logic   point;
	score_t score;
	level_t level;
	logic   win;

	modport sequencer (
		output clear,
		output point,
		input  score,
		input  level,
		input  win
	);

	modport keeper (
		input  clear,
		input  point,
		output score,
		output level,
		output win
	);
endinterface

/* speedTimer.sv */
// Speed timer
// Loadable tick counter that flags the end of each period
`timescale 1ns/1ns

module speedTimer
	import gameControl_pkg::*;
(
	input  logic       SC_STATEMACHINE_GENERAL_CLOCK_50,
	input  logic       SC_STATEMACHINE_GENERAL_RESET_InHigh,
	speedTimerIf.timer tmr
);

	// Compare value from the last load
	speedCount_t periodReg;
	// Ticks counted since load or last expiry
	speedCount_t countReg;
	// Count has reached the compare value
	logic        atEnd;

	// ========================================================================
	// Period register
	// ========================================================================
	always_ff @(posedge SC_STATEMACHINE_GENERAL_CLOCK_50)
	begin
		if (tmr.load)
			periodReg <= tmr.period;
	end

	// End of period, only while counting
	assign atEnd = tmr.run && (countReg == periodReg);

	// ========================================================================
	// Tick counter
	// ========================================================================
	always_ff @(posedge SC_STATEMACHINE_GENERAL_CLOCK_50 or
		posedge SC_STATEMACHINE_GENERAL_RESET_InHigh)
	begin
		if (SC_STATEMACHINE_GENERAL_RESET_InHigh)
		begin
			countReg <= '0;
		end
		else if (tmr.load)
		begin
			// A fresh load wins over a pending end of period
			countReg <= '0;
		end
		else if (atEnd)
		begin
			// Restart for the next period
			countReg <= '0;
		end
		else if (tmr.run)
		begin
			countReg <= countReg + 1'b1;
		end
	end

	// Period of N+1 ticks per expiry when N is loaded
	assign tmr.expired = atEnd;

endmodule

/* scoreKeeper.sv */
// Score keeper
// Saturating point counter with level and win decode
`timescale 1ns/1ns

module scoreKeeper
	import gameControl_pkg::*;
(
	input  logic        SC_STATEMACHINE_GENERAL_CLOCK_50,
	input  logic        SC_STATEMACHINE_GENERAL_RESET_InHigh,
	scoreIf.keeper      keep
);

	`include "gameControl_settings.svh"

	localparam score_t SCORE_MAX = '1;

	score_t scoreReg;

	// ========================================================================
	// Point counter
	// ========================================================================
	always_ff @(posedge SC_STATEMACHINE_GENERAL_CLOCK_50 or
		posedge SC_STATEMACHINE_GENERAL_RESET_InHigh)
	begin
		if (SC_STATEMACHINE_GENERAL_RESET_InHigh)
		begin
			scoreReg <= '0;
		end
		else if (keep.clear)
		begin
			scoreReg <= '0;
		end
		else if (keep.point && (scoreReg != SCORE_MAX))
		begin
			// Holds at the top value
			scoreReg <= scoreReg + 1'b1;
		end
	end

	assign keep.score = scoreReg;

	// ========================================================================
	// Level and win decode
	// ========================================================================
	assign keep.win = (scoreReg >= score_t'(`GC_WIN_SCORE));

	always_comb
	begin
		if (scoreReg >= score_t'(`GC_LEVEL3_SCORE))
			keep.level = levelThree;
		else if (scoreReg >= score_t'(`GC_LEVEL2_SCORE))
			keep.level = levelTwo;
		else
			keep.level = levelOne;
	end

endmodule

/* gameSequencer.sv */
// Game sequencer
// FSM for idle, countdown, level banners, road steps, lose and win screens
// Also picks the timer periods and issues clear and point pulses
`timescale 1ns/1ns

module gameSequencer
	import gameControl_pkg::*;
(
	input  logic            SC_STATEMACHINE_GENERAL_CLOCK_50,
	input  logic            SC_STATEMACHINE_GENERAL_RESET_InHigh,
	input  logic            startButton,
	input  logic            crashPlayer1,
	input  logic            crashPlayer2,
	input  logic            stepReady,
	output logic            stepValid,
	output stepKind_t       stepKind,
	output screen_t         screen,
	speedTimerIf.sequencer  tmr,
	scoreIf.sequencer       keep
);

	`include "gameControl_settings.svh"

	seqState_t stateReg;
	seqState_t stateNext;
	level_t    levelReg;
	level_t    levelNext;
	stepKind_t kindReg;
	stepKind_t kindNext;
	logic      loserIsPlayer1;
	logic      loserNext;

	// Step period for a level, one less since the timer counts from zero
	function automatic speedCount_t levelPeriod(input level_t lvl);
		case (lvl)
			levelTwo:   return speedCount_t'(`GC_LEVEL2_TICKS - 1);
			levelThree: return speedCount_t'(`GC_LEVEL3_TICKS - 1);
			default:    return speedCount_t'(`GC_LEVEL1_TICKS - 1);
		endcase
	endfunction

	// ========================================================================
	// Next state logic
	// ========================================================================
	always_comb
	begin
		stateNext  = stateReg;
		levelNext  = levelReg;
		kindNext   = kindReg;
		loserNext  = loserIsPlayer1;
		tmr.load   = 1'b0;
		tmr.period = '0;
		keep.clear = 1'b0;
		keep.point = 1'b0;
		case (stateReg)
			stateIdle:
			begin
				if (startButton)
				begin
					stateNext  = stateGo;
					keep.clear = 1'b1;
					tmr.load   = 1'b1;
					tmr.period = speedCount_t'(`GC_GO_TICKS - 1);
				end
			end
			stateGo:
			begin
				if (tmr.expired)
				begin
					stateNext  = stateBanner;
					levelNext  = levelOne;
					tmr.load   = 1'b1;
					tmr.period = speedCount_t'(`GC_BANNER_TICKS - 1);
				end
			end
			stateBanner:
			begin
				// Every banner restarts the road with new cars
				if (tmr.expired)
				begin
					stateNext  = stateRun;
					kindNext   = addCars;
					tmr.load   = 1'b1;
					tmr.period = levelPeriod(levelReg);
				end
			end
			stateRun:
			begin
				if (crashPlayer1 || crashPlayer2)
				begin
					// Player 1 takes priority
					stateNext  = stateLose;
					loserNext  = crashPlayer1;
					tmr.load   = 1'b1;
					tmr.period = speedCount_t'(`GC_LOSE_TICKS - 1);
				end
				else if (keep.win)
				begin
					stateNext = stateWin;
				end
				else if (keep.level > levelReg)
				begin
					stateNext  = stateBanner;
					levelNext  = keep.level;
					tmr.load   = 1'b1;
					tmr.period = speedCount_t'(`GC_BANNER_TICKS - 1);
				end
				else if (tmr.expired)
				begin
					stateNext = stateStepOffer;
				end
			end
			stateStepOffer:
			begin
				// Held until the display engine takes the step
				if (stepReady)
				begin
					stateNext  = stateRun;
					keep.point = 1'b1;
					kindNext   = (kindReg == addCars) ? moveCars : addCars;
				end
			end
			stateLose:
			begin
				if (tmr.expired)
					stateNext = stateIdle;
			end
			stateWin:
			begin
				stateNext = stateWin;
			end
			default:
			begin
				stateNext = stateIdle;
			end
		endcase
	end

	// ========================================================================
	// State registers
	// ========================================================================
	always_ff @(posedge SC_STATEMACHINE_GENERAL_CLOCK_50 or
		posedge SC_STATEMACHINE_GENERAL_RESET_InHigh)
	begin
		if (SC_STATEMACHINE_GENERAL_RESET_InHigh)
		begin
			stateReg       <= stateIdle;
			levelReg       <= levelOne;
			kindReg        <= addCars;
			loserIsPlayer1 <= 1'b0;
		end
		else
		begin
			stateReg       <= stateNext;
			levelReg       <= levelNext;
			kindReg        <= kindNext;
			loserIsPlayer1 <= loserNext;
		end
	end

	// ========================================================================
	// Outputs
	// ========================================================================
	// Timer is paused while a step waits and in idle or win
	assign tmr.run = (stateReg inside {stateGo, stateBanner, stateRun, stateLose});

	assign stepValid = (stateReg == stateStepOffer);
	assign stepKind  = kindReg;

	always_comb
	begin
		case (stateReg)
			stateGo:        screen = screenGo;
			stateBanner:
			begin
				case (levelReg)
					levelTwo:   screen = screenLevel2;
					levelThree: screen = screenLevel3;
					default:    screen = screenLevel1;
				endcase
			end
			stateRun,
			stateStepOffer: screen = screenRun;
			stateLose:      screen = loserIsPlayer1 ? screenLosePlayer1 : screenLosePlayer2;
			stateWin:       screen = screenWin;
			default:        screen = screenIdle;
		endcase
	end

endmodule

/* gameControl.sv */
// Game controller top level
// Sequencer, speed timer and score keeper joined by their internal buses
`timescale 1ns/1ns

module gameControl
	import gameControl_pkg::*;
(
	input  logic      SC_STATEMACHINE_GENERAL_CLOCK_50,
	input  logic      SC_STATEMACHINE_GENERAL_RESET_InHigh,
	// Player and display inputs
	input  logic      startButton,
	input  logic      crashPlayer1,
	input  logic      crashPlayer2,
	input  logic      stepReady,
	// Road step command
	output logic      stepValid,
	output stepKind_t stepKind,
	// Display state
	output screen_t   screen,
	output score_t    score
);

	speedTimerIf tmrBus ();
	scoreIf      scoreBus ();

	// ========================================================================
	// Sequencer
	// ========================================================================
	gameSequencer sequencer_i (
		.SC_STATEMACHINE_GENERAL_CLOCK_50    (SC_STATEMACHINE_GENERAL_CLOCK_50),
		.SC_STATEMACHINE_GENERAL_RESET_InHigh(SC_STATEMACHINE_GENERAL_RESET_InHigh),
		.startButton                         (startButton),
		.crashPlayer1                        (crashPlayer1),
		.crashPlayer2                        (crashPlayer2),
		.stepReady                           (stepReady),
		.stepValid                           (stepValid),
		.stepKind                            (stepKind),
		.screen                              (screen),
		.tmr                                 (tmrBus.sequencer),
		.keep                                (scoreBus.sequencer)
	);

	// ========================================================================
	// Side parts
	// ========================================================================
	speedTimer timer_i (
		.SC_STATEMACHINE_GENERAL_CLOCK_50    (SC_STATEMACHINE_GENERAL_CLOCK_50),
		.SC_STATEMACHINE_GENERAL_RESET_InHigh(SC_STATEMACHINE_GENERAL_RESET_InHigh),
		.tmr                                 (tmrBus.timer)
	);

	scoreKeeper keeper_i (
		.SC_STATEMACHINE_GENERAL_CLOCK_50    (SC_STATEMACHINE_GENERAL_CLOCK_50),
		.SC_STATEMACHINE_GENERAL_RESET_InHigh(SC_STATEMACHINE_GENERAL_RESET_InHigh),
		.keep                                (scoreBus.keeper)
	);

	// Points for the display
	assign score = scoreBus.score;

endmodule

/* gameControl_props.sv */
// Bound checker for the game controller
// Step handshake, screen code range and score direction assertions
`timescale 1ns/1ns
`include "gameControl_settings.svh"

module gameControl_props
	import gameControl_pkg::*;
(
	input logic                   SC_STATEMACHINE_GENERAL_CLOCK_50,
	input logic                   SC_STATEMACHINE_GENERAL_RESET_InHigh,
	input logic                   startButton,
	input logic                   stepReady,
	input logic                   stepValid,
	input stepKind_t              stepKind,
	input screen_t                screen,
	input logic [`GC_SCORE_W-1:0] score
);

	// Count of failed assertions, read by the testbench
	int unsigned failCount = 0;

	// ========================================================================
	// Step handshake
	// ========================================================================
	stalledValidHeld: assert property (@(posedge SC_STATEMACHINE_GENERAL_CLOCK_50)
		disable iff (SC_STATEMACHINE_GENERAL_RESET_InHigh)
		stepValid && !stepReady |=> stepValid)
	else
	begin
		failCount++;
		$error("stepValid dropped before the step was accepted");
	end

	stalledKindStable: assert property (@(posedge SC_STATEMACHINE_GENERAL_CLOCK_50)
		disable iff (SC_STATEMACHINE_GENERAL_RESET_InHigh)
		stepValid && !stepReady |=> $stable(stepKind))
	else
	begin
		failCount++;
		$error("stepKind changed while the step was stalled");
	end

	// ========================================================================
	// Display outputs
	// ========================================================================
	screenInRange: assert property (@(posedge SC_STATEMACHINE_GENERAL_CLOCK_50)
		disable iff (SC_STATEMACHINE_GENERAL_RESET_InHigh)
		screen <= screenRun)
	else
	begin
		failCount++;
		$error("screen code above screenRun");
	end

	// Only a start in idle clears the points
	scoreNotFalling: assert property (@(posedge SC_STATEMACHINE_GENERAL_CLOCK_50)
		disable iff (SC_STATEMACHINE_GENERAL_RESET_InHigh)
		(score >= $past(score)) || $past(startButton))
	else
	begin
		failCount++;
		$error("score decreased without a start");
	end

endmodule

bind gameControl gameControl_props props_i (
	.SC_STATEMACHINE_GENERAL_CLOCK_50    (SC_STATEMACHINE_GENERAL_CLOCK_50),
	.SC_STATEMACHINE_GENERAL_RESET_InHigh(SC_STATEMACHINE_GENERAL_RESET_InHigh),
	.startButton                         (startButton),
	.stepReady                           (stepReady),
	.stepValid                           (stepValid),
	.stepKind                            (stepKind),
	.screen                              (screen),
	.score                               (score)
);

/* gameControl_tb.sv */
// Directed testbench for the game controller
// Clock and reset, step handshake driver, screen timing checks and verdict
`timescale 1ns/1ns
`include "gameControl_settings.svh"

module gameControl_tb
	import gameControl_pkg::*;
();

	localparam int STEP_TIMEOUT   = 200;
	localparam int SCREEN_TIMEOUT = 40;
	localparam int WIN_WINDOW     = 100;

	logic      SC_STATEMACHINE_GENERAL_CLOCK_50;
	logic      SC_STATEMACHINE_GENERAL_RESET_InHigh;
	logic      startButton;
	logic      crashPlayer1;
	logic      crashPlayer2;
	logic      stepReady;
	logic      stepValid;
	stepKind_t stepKind;
	screen_t   screen;
	score_t    score;

	int        seed;
	// Accepted steps since the last start
	int        handshakes;
	// Cycles a valid step waited for stepReady
	int        stallCycles;
	stepKind_t expectedKind;

	gameControl dut_i (
		.SC_STATEMACHINE_GENERAL_CLOCK_50    (SC_STATEMACHINE_GENERAL_CLOCK_50),
		.SC_STATEMACHINE_GENERAL_RESET_InHigh(SC_STATEMACHINE_GENERAL_RESET_InHigh),
		.startButton                         (startButton),
		.crashPlayer1                        (crashPlayer1),
		.crashPlayer2                        (crashPlayer2),
		.stepReady                           (stepReady),
		.stepValid                           (stepValid),
		.stepKind                            (stepKind),
		.screen                              (screen),
		.score                               (score)
	);

	initial
	begin
		SC_STATEMACHINE_GENERAL_CLOCK_50 = 1'b0;
		forever #20 SC_STATEMACHINE_GENERAL_CLOCK_50 = ~SC_STATEMACHINE_GENERAL_CLOCK_50;
	end

	// ========================================================================
	// Checks and waits
	// ========================================================================
	task automatic checkEqual(input int actual, input int expected, input string what);
		if (actual != expected)
		begin
			$display("Fail at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("Timeout at %0t ns: %s", $time, what);
		$display("TEST FAIL");
		$fatal(1, "Stopped on a timeout");
	endtask

	task automatic waitScreen(input screen_t target, input string what);
		int cycles;
		cycles = 0;
		while (screen != target)
		begin
			if (cycles >= SCREEN_TIMEOUT)
				reportTimeout(what);
			@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
			cycles++;
		end
	endtask

	task automatic waitScreenChange(input screen_t from, input string what);
		int cycles;
		cycles = 0;
		while (screen == from)
		begin
			if (cycles >= SCREEN_TIMEOUT)
				reportTimeout(what);
			@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
			cycles++;
		end
	endtask

	// Counts the cycles a screen stays up, starting at the current one
	task automatic holdScreen(input screen_t target, input int expectedCycles,
		input string what);
		int cycles;
		cycles = 1;
		@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		while (screen == target)
		begin
			if (cycles > expectedCycles + SCREEN_TIMEOUT)
				reportTimeout(what);
			cycles++;
			@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		end
		checkEqual(cycles, expectedCycles, what);
	endtask

	// ========================================================================
	// Game actions
	// ========================================================================
	task automatic startGame();
		@(posedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		startButton <= 1'b1;
		@(posedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		startButton <= 1'b0;
		@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		checkEqual(screen, screenGo, "screen after start");
		checkEqual(score, 0, "score after start");
		holdScreen(screenGo, `GC_GO_TICKS, "countdown length");
		checkEqual(screen, screenLevel1, "screen after countdown");
		holdScreen(screenLevel1, `GC_BANNER_TICKS, "level 1 banner length");
		checkEqual(screen, screenRun, "screen after level 1 banner");
		handshakes   = 0;
		expectedKind = addCars;
	endtask

	// Waits for one accepted step, optionally stalling stepReady at random
	task automatic acceptStep(input bit stall);
		int        cycles;
		int        randomWord;
		bit        stalled;
		stepKind_t heldKind;
		cycles   = 0;
		stalled  = 1'b0;
		heldKind = addCars;
		@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		while (!(stepValid && stepReady))
		begin
			if (stalled)
			begin
				checkEqual(stepValid, 1, "stalled step withdrawn");
				checkEqual(stepKind, heldKind, "step kind changed while stalled");
			end
			if (stepValid)
			begin
				stalled  = 1'b1;
				heldKind = stepKind;
				stallCycles++;
			end
			if (cycles >= STEP_TIMEOUT)
				reportTimeout("no step was accepted");
			cycles++;
			@(posedge SC_STATEMACHINE_GENERAL_CLOCK_50);
			randomWord = $random(seed);
			stepReady <= stall ? randomWord[0] : 1'b1;
			@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		end
		checkEqual(stepKind, expectedKind, "step kind");
		handshakes++;
		expectedKind = (expectedKind == addCars) ? moveCars : addCars;
		// Point shows one cycle after the handshake
		@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		checkEqual(stepValid, 0, "stepValid after an accepted step");
		checkEqual(score, handshakes, "score after an accepted step");
	endtask

	task automatic enterLevel(input screen_t banner);
		waitScreen(banner, "no level banner after the threshold score");
		holdScreen(banner, `GC_BANNER_TICKS, "level banner length");
		checkEqual(screen, screenRun, "screen after level banner");
		// Road restarts with new cars
		expectedKind = addCars;
	endtask

	task automatic stepTo(input int target, input bit stall);
		while (handshakes < target)
		begin
			acceptStep(stall);
			if (handshakes == `GC_LEVEL2_SCORE)
				enterLevel(screenLevel2);
			else if (handshakes == `GC_LEVEL3_SCORE)
				enterLevel(screenLevel3);
		end
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================
	task automatic testResetValues();
		@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		checkEqual(screen, screenIdle, "screen after reset");
		checkEqual(stepValid, 0, "stepValid after reset");
		checkEqual(score, 0, "score after reset");
	endtask

	task automatic testStartAndFirstLevel();
		startGame();
		@(posedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		stepReady <= 1'b1;
		stepTo(4, 1'b0);
	endtask

	task automatic testBackPressure();
		int stallsBefore;
		stallsBefore = stallCycles;
		stepTo(handshakes + 12, 1'b1);
		checkEqual(stallCycles > stallsBefore, 1, "steps stalled under back-pressure");
		@(posedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		stepReady <= 1'b1;
	endtask

	// Banner checks and the addCars restart sit in stepTo
	task automatic testLevelRises();
		stepTo(`GC_LEVEL3_SCORE, 1'b0);
	endtask

	task automatic testCrash();
		@(posedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		crashPlayer1 <= 1'b1;
		crashPlayer2 <= 1'b1;
		@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		waitScreenChange(screenRun, "no lose screen after a crash");
		checkEqual(screen, screenLosePlayer1, "lose screen on a double crash");
		@(posedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		crashPlayer1 <= 1'b0;
		crashPlayer2 <= 1'b0;
		// One lose cycle went by while the crash inputs dropped
		@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		checkEqual(screen, screenLosePlayer1, "lose screen held");
		holdScreen(screenLosePlayer1, `GC_LOSE_TICKS - 1, "lose screen length");
		checkEqual(screen, screenIdle, "screen after lose pause");
		startGame();
	endtask

	task automatic testWin();
		stepTo(`GC_WIN_SCORE, 1'b1);
		waitScreen(screenWin, "no win screen at the top score");
		checkEqual(score, `GC_WIN_SCORE, "score on the win screen");
		repeat (WIN_WINDOW)
		begin
			@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
			checkEqual(stepValid, 0, "stepValid after win");
			checkEqual(screen, screenWin, "screen after win");
		end
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================
	initial
	begin
		seed                                 = 3;
		handshakes                           = 0;
		stallCycles                          = 0;
		expectedKind                         = addCars;
		SC_STATEMACHINE_GENERAL_RESET_InHigh = 1'b1;
		startButton                          = 1'b0;
		crashPlayer1                         = 1'b0;
		crashPlayer2                         = 1'b0;
		stepReady                            = 1'b0;
		repeat (16) @(posedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		SC_STATEMACHINE_GENERAL_RESET_InHigh <= 1'b0;

		testResetValues();
		testStartAndFirstLevel();
		testBackPressure();
		testLevelRises();
		testCrash();
		testWin();

		@(negedge SC_STATEMACHINE_GENERAL_CLOCK_50);
		if (dut_i.props_i.failCount == 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
		begin
			$display("TEST FAIL");
			$fatal(1, "Bound assertions reported errors");
		end
	end

endmodule

/* gameControl.f */
+incdir+.
gameControl_pkg.sv
gameControl_if.sv
speedTimer.sv
scoreKeeper.sv
gameSequencer.sv
gameControl.sv
gameControl_props.sv
gameControl_tb.sv

/* Bender.yml */
package:
  name: gameControl

export_include_dirs:
  - .

sources:
  # Design
  - gameControl_pkg.sv
  - gameControl_if.sv
  - speedTimer.sv
  - scoreKeeper.sv
  - gameSequencer.sv
  - gameControl.sv
  # Testbench and bound checker
  - target: test
    files:
      - gameControl_props.sv
      - gameControl_tb.sv
